/* hw/mem_test_pkg.sv */
// memory tester package: widths, burst constants, axi channel structs, fsm state enums
`default_nettype none

package mem_test_pkg;

	// -------------------------------------------------------------------------
	// widths
	// -------------------------------------------------------------------------
	// byte address and one 32 bit beat
	typedef logic [31:0] adrs_t;
	typedef logic [31:0] data_t;
	// beat index inside a burst
	typedef logic [1:0]  beat_t;
	// axi len field, beats minus one
	typedef logic [7:0]  burst_len_t;
	typedef logic [1:0]  resp_t;

	// -------------------------------------------------------------------------
	// burst and memory constants
	// -------------------------------------------------------------------------
	localparam int         BURST_BEATS   = 4;
	localparam int         BURST_BYTES   = 16;
	localparam int         WORD_LSB      = 2;
	localparam beat_t      BEAT_LAST     = beat_t'(BURST_BEATS - 1);
	localparam burst_len_t BURST_LEN     = burst_len_t'(BURST_BEATS - 1);
	// 4 KB model memory
	localparam int         MEM_WORDS     = 1024;
	localparam int         MEM_ADRS_BITS = $clog2(MEM_WORDS);
	typedef logic [MEM_ADRS_BITS-1:0] mem_idx_t;
	// okay and slave error codes
	localparam resp_t      RESP_OKAY     = 2'b00;
	localparam resp_t      RESP_SLVERR   = 2'b10;

	// -------------------------------------------------------------------------
	// axi channel payloads, valid and ready travel beside them
	// -------------------------------------------------------------------------
	typedef struct packed {
		adrs_t      addr;
		burst_len_t len;
	} axi_aw_t;

	typedef struct packed {
		adrs_t      addr;
		burst_len_t len;
	} axi_ar_t;

	typedef struct packed {
		data_t data;
		logic  last;
	} axi_w_t;

	typedef struct packed {
		data_t data;
		logic  last;
		resp_t resp;
	} axi_r_t;

	typedef struct packed {
		resp_t resp;
	} axi_b_t;

	// fsm states
	typedef enum logic [1:0] {CTRL_IDLE, CTRL_WRITE, CTRL_READ, CTRL_DONE} ctrl_state_t;
	typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_t;
	typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;

endpackage

`default_nettype wire

/* hw/mem_test_ctrl.sv */
// test sequencer: address range walk over write and read phases, status flags
`timescale 1ns/1ps
`default_nettype none

module mem_test_ctrl
	import mem_test_pkg::*;
(
	input  wire        iCLK,
	input  wire        iRST,
	input  wire        i_cfg_done,
	input  wire        i_start,
	input  wire adrs_t i_start_adrs,
	input  wire adrs_t i_stop_adrs,
	input  wire        i_wr_done,
	input  wire        i_rd_done,
	input  wire        i_rd_fail,
	input  wire adrs_t i_rd_fail_adrs,
	output logic       o_wr_start,
	output logic       o_rd_start,
	output adrs_t      o_burst_adrs,
	output logic       o_test_run,
	output logic       o_test_done,
	output logic       o_test_fail,
	output adrs_t      o_fail_adrs
);

	ctrl_state_t state;
	// range captured at start
	adrs_t       start_q;
	adrs_t       stop_q;
	adrs_t       next_adrs;
	logic        last_burst;
	logic        start_ok;

	// start only when calibrated and idle
	assign start_ok   = i_start && i_cfg_done && !o_test_run;
	assign next_adrs  = o_burst_adrs + adrs_t'(BURST_BYTES);
	// stop address is exclusive
	assign last_burst = (next_adrs >= stop_q);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state       <= CTRL_IDLE;
			o_wr_start  <= 1'b0;
			o_rd_start  <= 1'b0;
			o_test_run  <= 1'b0;
			o_test_done <= 1'b0;
			o_test_fail <= 1'b0;
		end
		else
		begin
			// start strobes are single cycle
			o_wr_start <= 1'b0;
			o_rd_start <= 1'b0;
			case (state)
				CTRL_IDLE, CTRL_DONE:
				begin
					if (start_ok)
					begin
						state       <= CTRL_WRITE;
						o_wr_start  <= 1'b1;
						o_test_run  <= 1'b1;
						o_test_done <= 1'b0;
						o_test_fail <= 1'b0;
					end
				end
				CTRL_WRITE:
				begin
					if (i_wr_done)
					begin
						// end of range, turn around to read phase
						if (last_burst)
						begin
							state      <= CTRL_READ;
							o_rd_start <= 1'b1;
						end
						else
							o_wr_start <= 1'b1;
					end
				end
				CTRL_READ:
				begin
					if (i_rd_done)
					begin
						// first bad word ends the test
						if (i_rd_fail || last_burst)
						begin
							state       <= CTRL_DONE;
							o_test_run  <= 1'b0;
							o_test_done <= 1'b1;
							o_test_fail <= i_rd_fail;
						end
						else
							o_rd_start <= 1'b1;
					end
				end
				default:
					state <= CTRL_IDLE;
			endcase
		end
	end

	// burst base and fail address
	always_ff @(posedge iCLK)
	begin
		if (start_ok)
		begin
			start_q      <= i_start_adrs;
			stop_q       <= i_stop_adrs;
			o_burst_adrs <= i_start_adrs;
		end
		else if (state == CTRL_WRITE && i_wr_done)
			o_burst_adrs <= last_burst ? start_q : next_adrs;
		else if (state == CTRL_READ && i_rd_done && !last_burst)
			o_burst_adrs <= next_adrs;
		if (state == CTRL_READ && i_rd_done && i_rd_fail)
			o_fail_adrs <= i_rd_fail_adrs;
	end

endmodule

`default_nettype wire

/* hw/axi_burst_writer.sv */
// axi4 write burst engine: address, four pattern beats, response wait
`timescale 1ns/1ps
`default_nettype none

module axi_burst_writer
	import mem_test_pkg::*;
(
	input  wire         iCLK,
	input  wire         iRST,
	input  wire         i_start,
	input  wire adrs_t  i_base_adrs,
	input  wire data_t  i_seed,
	input  wire         i_awready,
	input  wire         i_wready,
	input  wire axi_b_t i_b,
	input  wire         i_bvalid,
	output axi_aw_t     o_aw,
	output logic        o_awvalid,
	output axi_w_t      o_w,
	output logic        o_wvalid,
	output logic        o_bready,
	output logic        o_done
);

	wr_state_t state;
	adrs_t     base_q;
	beat_t     beat;
	// byte address of the current beat
	adrs_t     beat_adrs;

	assign beat_adrs = base_q + (adrs_t'(beat) << WORD_LSB);

	// ------------------------------------------------------------------------
	// channel payloads
	// ------------------------------------------------------------------------
	// base and beat only move on handshakes so payloads hold while valid
	assign o_aw.addr = base_q;
	assign o_aw.len  = BURST_LEN;
	// pattern word is address xor seed
	assign o_w.data  = beat_adrs ^ i_seed;
	assign o_w.last  = (beat == BEAT_LAST);

	// ------------------------------------------------------------------------
	// burst fsm
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state     <= WR_IDLE;
			beat      <= '0;
			o_awvalid <= 1'b0;
			o_wvalid  <= 1'b0;
			o_bready  <= 1'b0;
			o_done    <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			case (state)
				WR_IDLE:
				begin
					if (i_start)
					begin
						beat      <= '0;
						o_awvalid <= 1'b1;
						state     <= WR_ADDR;
					end
				end
				WR_ADDR:
				begin
					// address accepted, data follows
					if (i_awready)
					begin
						o_awvalid <= 1'b0;
						o_wvalid  <= 1'b1;
						state     <= WR_DATA;
					end
				end
				WR_DATA:
				begin
					if (i_wready)
					begin
						if (o_w.last)
						begin
							o_wvalid <= 1'b0;
							o_bready <= 1'b1;
							state    <= WR_RESP;
						end
						else
							beat <= beat + 1'b1;
					end
				end
				WR_RESP:
				begin
					// bresp not inspected, readback catches bad writes
					if (i_bvalid)
					begin
						o_bready <= 1'b0;
						o_done   <= 1'b1;
						state    <= WR_IDLE;
					end
				end
				default:
					state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (state == WR_IDLE && i_start)
			base_q <= i_base_adrs;
	end

endmodule

`default_nettype wire

/* hw/axi_burst_checker.sv */
// axi4 read burst checker: read request, per beat pattern compare, first mismatch report
`timescale 1ns/1ps
`default_nettype none

module axi_burst_checker
	import mem_test_pkg::*;
(
	input  wire         iCLK,
	input  wire         iRST,
	input  wire         i_start,
	input  wire adrs_t  i_base_adrs,
	input  wire data_t  i_seed,
	input  wire         i_arready,
	input  wire axi_r_t i_r,
	input  wire         i_rvalid,
	output axi_ar_t     o_ar,
	output logic        o_arvalid,
	output logic        o_rready,
	output logic        o_done,
	output logic        o_fail,
	output adrs_t       o_fail_adrs
);

	rd_state_t state;
	adrs_t     base_q;
	beat_t     beat;
	adrs_t     beat_adrs;
	data_t     expect_data;
	logic      beat_take;
	logic      beat_bad;

	// expected word for the beat in flight
	assign beat_adrs   = base_q + (adrs_t'(beat) << WORD_LSB);
	assign expect_data = beat_adrs ^ i_seed;
	assign beat_take   = (state == RD_DATA) && i_rvalid && o_rready;
	// corrupted data or error response
	assign beat_bad    = (i_r.data != expect_data) || (i_r.resp != RESP_OKAY);

	assign o_ar.addr = base_q;
	assign o_ar.len  = BURST_LEN;

	// ------------------------------------------------------------------------
	// burst fsm
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state     <= RD_IDLE;
			beat      <= '0;
			o_arvalid <= 1'b0;
			o_rready  <= 1'b0;
			o_done    <= 1'b0;
			o_fail    <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			case (state)
				RD_IDLE:
				begin
					// fail flag cleared per burst
					if (i_start)
					begin
						beat      <= '0;
						o_fail    <= 1'b0;
						o_arvalid <= 1'b1;
						state     <= RD_ADDR;
					end
				end
				RD_ADDR:
				begin
					if (i_arready)
					begin
						o_arvalid <= 1'b0;
						o_rready  <= 1'b1;
						state     <= RD_DATA;
					end
				end
				RD_DATA:
				begin
					if (beat_take)
					begin
						beat <= beat + 1'b1;
						// keep only the first bad beat
						if (beat_bad)
							o_fail <= 1'b1;
						// done lands one cycle after the last beat
						if (i_r.last)
						begin
							o_rready <= 1'b0;
							o_done   <= 1'b1;
							state    <= RD_IDLE;
						end
					end
				end
				default:
					state <= RD_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// base and fail address capture
	// ------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (state == RD_IDLE && i_start)
			base_q <= i_base_adrs;
		if (beat_take && beat_bad && !o_fail)
			o_fail_adrs <= beat_adrs;
	end

endmodule

`default_nettype wire

/* hw/axi_sram_model.sv */
// axi4 slave memory model: incrementing bursts, lfsr back-pressure, read fault injection
`timescale 1ns/1ps
`default_nettype none

module axi_sram_model
	import mem_test_pkg::*;
(
	input  wire          iCLK,
	input  wire          iRST,
	input  wire axi_aw_t i_aw,
	input  wire          i_awvalid,
	input  wire axi_w_t  i_w,
	input  wire          i_wvalid,
	input  wire          i_bready,
	input  wire axi_ar_t i_ar,
	input  wire          i_arvalid,
	input  wire          i_rready,
	input  wire          i_fault_en,
	input  wire adrs_t   i_fault_adrs,
	input  wire data_t   i_fault_mask,
	output logic         o_awready,
	output logic         o_wready,
	output axi_b_t       o_b,
	output logic         o_bvalid,
	output logic         o_arready,
	output axi_r_t       o_r,
	output logic         o_rvalid
);

	data_t      mem [MEM_WORDS];
	// stall source
	logic [7:0] lfsr;
	// write side
	logic       wr_busy;
	mem_idx_t   wr_idx;
	burst_len_t wr_left;
	logic       wr_beat;
	resp_t      b_resp;
	// read side
	logic       rd_busy;
	mem_idx_t   rd_idx;
	burst_len_t rd_left;
	logic       rd_present;
	data_t      r_data;
	logic       r_last;
	logic       fault_hit;

	// x^8 + x^6 + x^5 + x^4 + 1, never all zero
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			lfsr <= 8'h01;
		else
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
	end

	// ------------------------------------------------------------------------
	// write channels
	// ------------------------------------------------------------------------
	assign o_wready = wr_busy && lfsr[0];
	assign wr_beat  = o_wready && i_wvalid;
	assign o_b.resp = b_resp;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			o_awready <= 1'b0;
			wr_busy   <= 1'b0;
			o_bvalid  <= 1'b0;
		end
		else
		begin
			// awready only while no burst or response pending
			if (o_awready && i_awvalid)
			begin
				o_awready <= 1'b0;
				wr_busy   <= 1'b1;
			end
			else if (!wr_busy && !o_bvalid)
				o_awready <= 1'b1;
			if (wr_beat && wr_left == '0)
			begin
				wr_busy  <= 1'b0;
				o_bvalid <= 1'b1;
			end
			if (o_bvalid && i_bready)
				o_bvalid <= 1'b0;
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (o_awready && i_awvalid)
		begin
			wr_idx  <= i_aw.addr[WORD_LSB +: MEM_ADRS_BITS];
			wr_left <= i_aw.len;
		end
		else if (wr_beat)
		begin
			mem[wr_idx] <= i_w.data;
			wr_idx      <= wr_idx + 1'b1;
			wr_left     <= wr_left - 1'b1;
		end
		// wlast must line up with awlen
		if (wr_beat && wr_left == '0)
			b_resp <= i_w.last ? RESP_OKAY : RESP_SLVERR;
	end

	// ------------------------------------------------------------------------
	// read channels
	// ------------------------------------------------------------------------
	// fault address aliases into the 4 KB window
	assign fault_hit  = i_fault_en && (rd_idx == i_fault_adrs[WORD_LSB +: MEM_ADRS_BITS]);
	assign rd_present = rd_busy && !o_rvalid && lfsr[0];
	assign o_r.data   = r_data;
	assign o_r.last   = r_last;
	assign o_r.resp   = RESP_OKAY;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			o_arready <= 1'b0;
			rd_busy   <= 1'b0;
			o_rvalid  <= 1'b0;
		end
		else
		begin
			if (o_arready && i_arvalid)
			begin
				o_arready <= 1'b0;
				rd_busy   <= 1'b1;
			end
			else if (!rd_busy)
				o_arready <= 1'b1;
			// beat held until taken
			if (rd_present)
				o_rvalid <= 1'b1;
			if (o_rvalid && i_rready)
			begin
				o_rvalid <= 1'b0;
				if (r_last)
					rd_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (o_arready && i_arvalid)
		begin
			rd_idx  <= i_ar.addr[WORD_LSB +: MEM_ADRS_BITS];
			rd_left <= i_ar.len;
		end
		else if (rd_present)
		begin
			r_data  <= mem[rd_idx] ^ (fault_hit ? i_fault_mask : '0);
			r_last  <= (rd_left == '0);
			rd_idx  <= rd_idx + 1'b1;
			rd_left <= rd_left - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/mem_test_top.sv */
// memory tester top: sequencer, burst writer, burst checker, axi memory model
`timescale 1ns/1ps
`default_nettype none

module mem_test_top
	import mem_test_pkg::*;
(
	input  wire        iCLK,
	input  wire        iRST,
	input  wire        i_cfg_done,
	input  wire        i_start,
	input  wire adrs_t i_start_adrs,
	input  wire adrs_t i_stop_adrs,
	input  wire data_t i_seed,
	input  wire        i_fault_en,
	input  wire adrs_t i_fault_adrs,
	input  wire data_t i_fault_mask,
	output wire        o_test_run,
	output wire        o_test_done,
	output wire        o_test_fail,
	output wire adrs_t o_fail_adrs
);

	// ------------------------------------------------------------------------
	// sequencer to engines
	// ------------------------------------------------------------------------
	logic    wr_start;
	logic    rd_start;
	adrs_t   burst_adrs;
	logic    wr_done;
	logic    rd_done;
	logic    rd_fail;
	adrs_t   rd_fail_adrs;

	// axi channels
	axi_aw_t aw;
	logic    awvalid;
	logic    awready;
	axi_w_t  w;
	logic    wvalid;
	logic    wready;
	axi_b_t  b;
	logic    bvalid;
	logic    bready;
	axi_ar_t ar;
	logic    arvalid;
	logic    arready;
	axi_r_t  r;
	logic    rvalid;
	logic    rready;

	mem_test_ctrl u_ctrl (
		.iCLK           (iCLK),
		.iRST           (iRST),
		.i_cfg_done     (i_cfg_done),
		.i_start        (i_start),
		.i_start_adrs   (i_start_adrs),
		.i_stop_adrs    (i_stop_adrs),
		.i_wr_done      (wr_done),
		.i_rd_done      (rd_done),
		.i_rd_fail      (rd_fail),
		.i_rd_fail_adrs (rd_fail_adrs),
		.o_wr_start     (wr_start),
		.o_rd_start     (rd_start),
		.o_burst_adrs   (burst_adrs),
		.o_test_run     (o_test_run),
		.o_test_done    (o_test_done),
		.o_test_fail    (o_test_fail),
		.o_fail_adrs    (o_fail_adrs)
	);

	axi_burst_writer u_writer (
		.iCLK        (iCLK),
		.iRST        (iRST),
		.i_start     (wr_start),
		.i_base_adrs (burst_adrs),
		.i_seed      (i_seed),
		.i_awready   (awready),
		.i_wready    (wready),
		.i_b         (b),
		.i_bvalid    (bvalid),
		.o_aw        (aw),
		.o_awvalid   (awvalid),
		.o_w         (w),
		.o_wvalid    (wvalid),
		.o_bready    (bready),
		.o_done      (wr_done)
	);

	axi_burst_checker u_checker (
		.iCLK        (iCLK),
		.iRST        (iRST),
		.i_start     (rd_start),
		.i_base_adrs (burst_adrs),
		.i_seed      (i_seed),
		.i_arready   (arready),
		.i_r         (r),
		.i_rvalid    (rvalid),
		.o_ar        (ar),
		.o_arvalid   (arvalid),
		.o_rready    (rready),
		.o_done      (rd_done),
		.o_fail      (rd_fail),
		.o_fail_adrs (rd_fail_adrs)
	);

	// stands in for the ddr controller
	axi_sram_model u_mem (
		.iCLK         (iCLK),
		.iRST         (iRST),
		.i_aw         (aw),
		.i_awvalid    (awvalid),
		.i_w          (w),
		.i_wvalid     (wvalid),
		.i_bready     (bready),
		.i_ar         (ar),
		.i_arvalid    (arvalid),
		.i_rready     (rready),
		.i_fault_en   (i_fault_en),
		.i_fault_adrs (i_fault_adrs),
		.i_fault_mask (i_fault_mask),
		.o_awready    (awready),
		.o_wready     (wready),
		.o_b          (b),
		.o_bvalid     (bvalid),
		.o_arready    (arready),
		.o_r          (r),
		.o_rvalid     (rvalid)
	);

endmodule

`default_nettype wire

/* tb/tb_mem_test.sv */
// memory tester testbench: stimulus table, clock, reset, value check, polled waits with timeouts
`timescale 1ns/1ps
`default_nettype none

module tb_mem_test
	import mem_test_pkg::*;
();

	localparam int NUM_ROWS       = 6;
	localparam int TIMEOUT_CYCLES = 5000;
	localparam int IDLE_CYCLES    = 20;

	// one table row, inputs then expected results
	typedef struct packed {
		adrs_t start_adrs;
		adrs_t stop_adrs;
		data_t seed;
		logic  fault_en;
		adrs_t fault_adrs;
		data_t fault_mask;
		logic  exp_fail;
		adrs_t exp_fail_adrs;
	} test_row_t;

	logic      iCLK;
	logic      iRST;
	logic      cfg_done;
	logic      start;
	adrs_t     start_adrs;
	adrs_t     stop_adrs;
	data_t     seed;
	logic      fault_en;
	adrs_t     fault_adrs;
	data_t     fault_mask;
	logic      test_run;
	logic      test_done;
	logic      test_fail;
	adrs_t     fail_adrs;

	test_row_t rows [NUM_ROWS];
	int        error_count;
	int        check_count;
	int        rows_run;
	int        row_idx;
	int        seed_dummy;
	logic      timed_out;

	mem_test_top DUT (
		.iCLK         (iCLK),
		.iRST         (iRST),
		.i_cfg_done   (cfg_done),
		.i_start      (start),
		.i_start_adrs (start_adrs),
		.i_stop_adrs  (stop_adrs),
		.i_seed       (seed),
		.i_fault_en   (fault_en),
		.i_fault_adrs (fault_adrs),
		.i_fault_mask (fault_mask),
		.o_test_run   (test_run),
		.o_test_done  (test_done),
		.o_test_fail  (test_fail),
		.o_fail_adrs  (fail_adrs)
	);

	// 10 ns clock
	initial
	begin
		iCLK = 1'b0;
		forever #5 iCLK = ~iCLK;
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			$display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h",
				$time, name, got, expected);
			error_count++;
		end
	endtask

	// inputs change 1 ns after the edge
	task automatic step();
		@(posedge iCLK);
		#1;
	endtask

	// poll o_test_done, give up after the timeout
	task automatic wait_test_done(output logic hit_timeout);
		int cycles;
		cycles = 0;
		while (test_done !== 1'b1 && cycles < TIMEOUT_CYCLES)
		begin
			step();
			cycles++;
		end
		hit_timeout = (test_done !== 1'b1);
	endtask

	// start, stop, seed, fault en, fault adrs, mask, exp fail, exp fail adrs
	task automatic load_rows();
		rows[0] = '{32'h0000_0000, 32'h0000_0100, 32'hA5A5_5A5A, 1'b0, 32'h0, 32'h0, 1'b0, 32'h0};
		rows[1] = '{32'h0000_0200, 32'h0000_0400, 32'h1234_8765, 1'b0, 32'h0, 32'h0, 1'b0, 32'h0};
		// fault inside the range
		rows[2] = '{32'h0000_0000, 32'h0000_0100, 32'hDEAD_BEEF, 1'b1, 32'h0000_0048, 32'h0,
			1'b1, 32'h0000_0048};
		// clean run right after a failing one
		rows[3] = '{32'h0000_0000, 32'h0000_0100, 32'h0F0F_F0F0, 1'b0, 32'h0, 32'h0, 1'b0, 32'h0};
		// fault word below the range
		rows[4] = '{32'h0000_0100, 32'h0000_0200, 32'h5555_AAAA, 1'b1, 32'h0000_0080, 32'h0,
			1'b0, 32'h0};
		// last word of a wider range
		rows[5] = '{32'h0000_0200, 32'h0000_0400, 32'hC3C3_3C3C, 1'b1, 32'h0000_03FC, 32'h0,
			1'b1, 32'h0000_03FC};
		// random nonzero masks on fault rows
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			if (rows[i].fault_en)
			begin
				rows[i].fault_mask = $urandom();
				if (rows[i].fault_mask == '0)
					rows[i].fault_mask = 32'h0000_0001;
			end
		end
	endtask

	task automatic run_row(input int idx, output logic hit_timeout);
		test_row_t row;
		int        errors_before;
		row           = rows[idx];
		errors_before = error_count;
		start_adrs    = row.start_adrs;
		stop_adrs     = row.stop_adrs;
		seed          = row.seed;
		fault_en      = row.fault_en;
		fault_adrs    = row.fault_adrs;
		fault_mask    = row.fault_mask;
		start         = 1'b1;
		step();
		start         = 1'b0;
		// run up, previous status cleared
		check_value("o_test_run", 32'(test_run), 32'h1);
		check_value("o_test_done", 32'(test_done), 32'h0);
		check_value("o_test_fail", 32'(test_fail), 32'h0);
		wait_test_done(hit_timeout);
		if (hit_timeout)
			$display("row %0d: o_test_done did not rise within %0d cycles", idx, TIMEOUT_CYCLES);
		else
		begin
			check_value("o_test_run", 32'(test_run), 32'h0);
			check_value("o_test_fail", 32'(test_fail), 32'(row.exp_fail));
			if (row.exp_fail)
				check_value("o_fail_adrs", fail_adrs, row.exp_fail_adrs);
		end
		$display("row %0d: range 0x%08h..0x%08h seed 0x%08h fault %0b -> %s", idx,
			row.start_adrs, row.stop_adrs, row.seed, row.fault_en,
			(hit_timeout || error_count != errors_before) ? "errors" : "ok");
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial
	begin
		iRST        = 1'b1;
		cfg_done    = 1'b0;
		start       = 1'b0;
		start_adrs  = '0;
		stop_adrs   = '0;
		seed        = '0;
		fault_en    = 1'b0;
		fault_adrs  = '0;
		fault_mask  = '0;
		error_count = 0;
		check_count = 0;
		rows_run    = 0;
		timed_out   = 1'b0;
		seed_dummy  = $urandom(32'he36f);
		load_rows();

		// reset for 4 cycles
		repeat (4) @(posedge iCLK);
		#1;
		iRST = 1'b0;
		check_value("o_test_run", 32'(test_run), 32'h0);
		check_value("o_test_done", 32'(test_done), 32'h0);
		check_value("o_test_fail", 32'(test_fail), 32'h0);

		// start ignored until calibration is reported
		start = 1'b1;
		step();
		start = 1'b0;
		for (int i = 0; i < IDLE_CYCLES; i++)
		begin
			check_value("o_test_run", 32'(test_run), 32'h0);
			step();
		end
		$display("idle check: start without cfg_done -> %s", (error_count == 0) ? "ok" : "errors");

		cfg_done = 1'b1;
		step();
		for (row_idx = 0; row_idx < NUM_ROWS && !timed_out; row_idx++)
		begin
			run_row(row_idx, timed_out);
			rows_run++;
			step();
		end

		$display("rows run %0d of %0d, checks %0d, errors %0d, timeout %0b",
			rows_run, NUM_ROWS, check_count, error_count, timed_out);
		if (error_count == 0 && !timed_out)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
hw/mem_test_pkg.sv
hw/mem_test_ctrl.sv
hw/axi_burst_writer.sv
hw/axi_burst_checker.sv
hw/axi_sram_model.sv
hw/mem_test_top.sv
tb/tb_mem_test.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_mem_test
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
